// File: source/sha_miner_pkg.sv
// Timing constants, step numbers, message block words, bus structs, debounce states
`default_nettype none

package sha_miner_pkg;

	////////////////////////////////////////
	// Debounce timing, all in clk cycles
	////////////////////////////////////////

	localparam int debounce_cnt_w = 10;	// Wide enough for the longest threshold

	localparam logic [debounce_cnt_w-1:0] press_cycles     = 10'd20;	// High time to accept
	localparam logic [debounce_cnt_w-1:0] pulse_end_cycles = 10'd100;	// End of pulse state
	localparam logic [debounce_cnt_w-1:0] long_cycles      = 10'd400;	// Hold threshold
	localparam logic [debounce_cnt_w-1:0] release_cycles   = 10'd300;	// Low time back to idle

	////////////////////////////////////////
	// Job step numbers
	////////////////////////////////////////

	localparam int step_w = 8;

	localparam logic [step_w-1:0] first_step    = 8'd1;	// Fetch of a fresh job
	localparam logic [step_w-1:0] block0_step   = 8'd2;	// Header block goes out
	localparam logic [step_w-1:0] repeat_step   = 8'd65;	// Re-entry, header midstate kept
	localparam logic [step_w-1:0] block1_step   = 8'd66;	// Tail block goes out
	localparam logic [step_w-1:0] job_last_step = 8'd129;	// Hash done

	// Rate window
	localparam int second_cycles = 1000;
	localparam int second_cnt_w  = $clog2(second_cycles);

	////////////////////////////////////////
	// Message block contents
	////////////////////////////////////////

	// Block header, first 64 bytes
	localparam logic [511:0] header_block = {
		32'h00000001, 32'h4cc2c57c, 32'h7905fd39, 32'h9965282c,
		32'h87fe259e, 32'h7da366e0, 32'h35dc087a, 32'h0000141f,
		32'h00000000, 32'h6427b649, 32'h2f2b0525, 32'h78fb4bc2,
		32'h3655ca4e, 32'h8b9e2b9b, 32'h69c88041, 32'hb2ac8c77
	};

	localparam logic [95:0] tail_prefix = 96'h1571d1be_4de69593_1a269421;	// Rest of header

	// 0x80 end marker, zero fill, then the 640-bit message length
	localparam logic [383:0] tail_padding = {32'h00000080, 320'h0, 32'h80020000};

	typedef logic [31:0] nonce_t;

	typedef struct packed {
		logic         valid;	// One-cycle strobe
		logic         index;	// 0 header, 1 tail
		logic [511:0] data;
	} msg_block_t;

	typedef struct packed {
		logic press;	// Single-cycle strobe
		logic hold;	// Level while held long
	} button_event_t;

	typedef struct packed {
		logic [47:0] total_ops;
		logic [23:0] ops_per_sec;
	} stats_t;

	typedef enum logic [2:0] {
		s_idle,
		s_wait_press,
		s_pulse,
		s_wait_long,
		s_long,
		s_wait_off,
		s_wait_loff
	} debounce_state_e;

endpackage

`default_nettype wire

// File: source/button_debounce.sv
// Fire button synchroniser, debounce FSM, press strobe and hold level
`timescale 1ns/10ps
`default_nettype none

module button_debounce
	import sha_miner_pkg::*;
(
	input  logic          clk,
	input  logic          reset,
	input  logic          button,
	output button_event_t event_out
);

	logic [2:0]                sync_q;	// Metastability chain
	logic                      button_s;	// Synchronised input
	debounce_state_e           state;
	logic [debounce_cnt_w-1:0] on_cnt;	// Time since press began
	logic [debounce_cnt_w-1:0] off_cnt;	// Time spent low after a press
	logic                      in_pulse;
	logic                      pulse_d;
	logic                      press_q;

	////////////////////////////////////////
	// Synchroniser
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			sync_q <= '0;
		end else begin
			sync_q <= {sync_q[1:0], button};
		end
	end

	assign button_s = sync_q[2];

	////////////////////////////////////////
	// Debounce FSM
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= s_idle;
		end else begin
			case (state)
				s_idle:       state <= button_s ? s_wait_press : s_idle;
				s_wait_press: begin
					if (!button_s)
						state <= s_idle;	// Glitch, drop it
					else if (on_cnt == press_cycles)
						state <= s_pulse;
				end
				s_pulse:      state <= (on_cnt == pulse_end_cycles) ? s_wait_long : s_pulse;
				s_wait_long: begin
					if (!button_s)
						state <= s_wait_off;
					else if (on_cnt >= long_cycles)
						state <= s_long;	// Held long enough
				end
				s_long:       state <= button_s ? s_long : s_wait_loff;
				s_wait_off: begin
					if (button_s)
						state <= s_wait_long;	// Bounce back, keep timing
					else if (off_cnt == release_cycles)
						state <= s_idle;
				end
				s_wait_loff: begin
					if (button_s)
						state <= s_long;
					else if (off_cnt == release_cycles)
						state <= s_idle;
				end
				default:      state <= s_idle;
			endcase
		end
	end

	// Counters, on_cnt saturates so a very long hold cannot wrap
	always_ff @(posedge clk) begin
		if (reset) begin
			on_cnt  <= '0;
			off_cnt <= '0;
		end else begin
			if (state == s_idle)
				on_cnt <= '0;
			else if (on_cnt != '1)
				on_cnt <= on_cnt + 1'b1;
			if (state == s_wait_off || state == s_wait_loff)
				off_cnt <= off_cnt + 1'b1;	// Low and waiting
			else
				off_cnt <= '0;
		end
	end

	// Rising edge of the pulse state gives one press
	assign in_pulse = (state == s_pulse);

	always_ff @(posedge clk) begin
		if (reset) begin
			pulse_d <= 1'b0;
			press_q <= 1'b0;
		end else begin
			pulse_d <= in_pulse;
			press_q <= in_pulse & ~pulse_d;
		end
	end

	assign event_out.press = press_q;
	assign event_out.hold  = (state == s_long) | (state == s_wait_loff);	// Until released

endmodule

`default_nettype wire

// File: source/hash_sequencer.sv
// Job step counter with fetch, load and finish strobe decode
`timescale 1ns/10ps
`default_nettype none

module hash_sequencer
	import sha_miner_pkg::*;
(
	input  logic          clk,
	input  logic          reset,
	input  button_event_t event_in,
	output logic          fetch,
	output logic          load0,
	output logic          load1,
	output logic          finish
);

	logic              go;	// Button asks for work
	logic [step_w-1:0] step;	// 0 is idle, 1..129 one job
	logic              at_last;

	assign go      = event_in.press | event_in.hold;
	assign at_last = (step == job_last_step);

	////////////////////////////////////////
	// Step counter
	////////////////////////////////////////

	// One job is two blocks of 64 rounds each plus setup steps.
	// A repeat skips the header block since its midstate is unchanged.
	always_ff @(posedge clk) begin
		if (reset) begin
			step <= '0;
		end else if (step == '0) begin
			step <= go ? first_step : '0;
		end else if (at_last) begin
			step <= go ? repeat_step : '0;	// Next nonce, tail only
		end else begin
			step <= step + 1'b1;
		end
	end

	////////////////////////////////////////
	// Strobe decode
	////////////////////////////////////////

	// All strobes come straight off the step register
	always_comb begin
		fetch  = (step == first_step) | (at_last & go);	// New nonce
		load0  = (step == block0_step);	// Header to the core
		load1  = (step == block1_step);	// Tail to the core
		finish = at_last;	// Hash complete
	end

endmodule

`default_nettype wire

// File: source/message_builder.sv
// Nonce counter, header and tail block capture, block issue on load strobes
`timescale 1ns/10ps
`default_nettype none

module message_builder
	import sha_miner_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       fetch,
	input  logic       load0,
	input  logic       load1,
	output msg_block_t block
);

	nonce_t       nonce_q;	// Next nonce to hand out
	logic [511:0] head_q;	// Captured header block
	logic [511:0] tail_q;	// Captured tail block with nonce
	logic         valid_q;
	logic         index_q;
	logic [511:0] data_q;

	////////////////////////////////////////
	// Nonce and block capture
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			nonce_q <= '0;
		end else if (fetch) begin
			nonce_q <= nonce_q + 1'b1;	// Wraps after 2^32 jobs
		end
	end

	// Blocks stay stable for the whole job
	always_ff @(posedge clk) begin
		if (fetch) begin
			head_q <= header_block;
			tail_q <= {tail_prefix, nonce_q, tail_padding};	// Current count goes in
		end
	end

	////////////////////////////////////////
	// Block issue
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= 1'b0;
			index_q <= 1'b0;
		end else begin
			valid_q <= load0 | load1;	// One cycle per load
			index_q <= load1;
		end
	end

	always_ff @(posedge clk) begin
		if (load0 | load1) begin
			data_q <= load1 ? tail_q : head_q;
		end
	end

	// No back-pressure, the core takes it on the valid cycle
	assign block.valid = valid_q;
	assign block.index = index_q;
	assign block.data  = data_q;

endmodule

`default_nettype wire

// File: source/rate_counter.sv
// Total job counter, one-second timer and per-second rate latch
`timescale 1ns/10ps
`default_nettype none

module rate_counter
	import sha_miner_pkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  logic   finish,
	output stats_t stats
);

	logic [47:0]             total_q;	// All finished jobs
	logic [23:0]             window_q;	// Finishes in current window
	logic [23:0]             rate_q;	// Last full window
	logic [second_cnt_w-1:0] sec_q;
	logic                    sec_tick;

	////////////////////////////////////////
	// One-second timer
	////////////////////////////////////////

	assign sec_tick = (sec_q == second_cnt_w'(second_cycles - 1));	// Last cycle of window

	always_ff @(posedge clk) begin
		if (reset) begin
			sec_q <= '0;
		end else begin
			sec_q <= sec_tick ? '0 : sec_q + 1'b1;
		end
	end

	////////////////////////////////////////
	// Counters
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			total_q  <= '0;
			window_q <= '0;
			rate_q   <= '0;
		end else begin
			if (finish)
				total_q <= total_q + 1'b1;
			if (sec_tick) begin
				rate_q   <= window_q;	// Window just ended
				window_q <= finish ? 24'd1 : 24'd0;	// Finish on the tick starts next window
			end else if (finish) begin
				window_q <= window_q + 1'b1;
			end
		end
	end

	assign stats.total_ops   = total_q;
	assign stats.ops_per_sec = rate_q;

endmodule

`default_nettype wire

// File: source/sha_miner_top.sv
// Top level with debounce, sequencer, message builder and rate counter
`timescale 1ns/10ps
`default_nettype none

module sha_miner_top
	import sha_miner_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       fire_button,
	output msg_block_t block,
	output stats_t     stats
);

	button_event_t fire_event;	// Press strobe and hold level
	logic          fetch;
	logic          load0;
	logic          load1;
	logic          finish;

	////////////////////////////////////////
	// Input side
	////////////////////////////////////////

	button_debounce i_button_debounce (
		.clk      (clk),
		.reset    (reset),
		.button   (fire_button),
		.event_out(fire_event)
	);

	////////////////////////////////////////
	// Job control and message blocks
	////////////////////////////////////////

	hash_sequencer i_hash_sequencer (
		.clk     (clk),
		.reset   (reset),
		.event_in(fire_event),
		.fetch   (fetch),
		.load0   (load0),
		.load1   (load1),
		.finish  (finish)
	);

	message_builder i_message_builder (
		.clk  (clk),
		.reset(reset),
		.fetch(fetch),
		.load0(load0),
		.load1(load1),
		.block(block)	// To the external hash core
	);

	// Statistics
	rate_counter i_rate_counter (
		.clk   (clk),
		.reset (reset),
		.finish(finish),
		.stats (stats)
	);

endmodule

`default_nettype wire

// File: dv/sha_miner_chk.sv
// Bound assertions on block strobe length, load spacing and job total
`timescale 1ns/10ps
`default_nettype none

module sha_miner_chk (
	input logic        clk,
	input logic        reset,
	input logic        block_valid,
	input logic        load0,
	input logic        load1,
	input logic [47:0] total_ops
);

	// Block strobe is one cycle wide
	valid_single: assert property (@(posedge clk) disable iff (reset)
		$past(block_valid) |-> !block_valid)
		else $error("block valid high on two cycles in a row");

	// Tail load one block of rounds after header load
	load_spacing: assert property (@(posedge clk) disable iff (reset)
		$past(load0, 64) |-> load1)
		else $error("load1 missing 64 cycles after load0");

	total_rising: assert property (@(posedge clk) disable iff (reset)
		total_ops >= $past(total_ops))
		else $error("total_ops decreased");

endmodule

bind sha_miner_top sha_miner_chk i_sha_miner_chk (
	.clk        (clk),
	.reset      (reset),
	.block_valid(block.valid),
	.load0      (load0),
	.load1      (load1),
	.total_ops  (stats.total_ops)
);

`default_nettype wire

// File: dv/tb_sha_miner.sv
// Testbench with clock, reset, LFSR button stimulus, block and stats model, checks, watchdog
`timescale 1ns/10ps
`default_nettype none

module tb_sha_miner
	import sha_miner_pkg::*;
();

	localparam int seed          = 25;
	localparam int n_glitches    = 10;
	localparam int n_presses     = 4;	// One more runs after the holds
	localparam int n_holds       = 2;
	localparam int job_cycles    = int'(job_last_step) + 1;
	localparam int tail_wait     = 2 * job_cycles;	// Release to tail block, worst case
	localparam int glitch_settle = 200;
	localparam int press_settle  = int'(release_cycles) + 150;
	localparam int hold_settle   = int'(release_cycles) + 2 * job_cycles + 40;
	localparam int watchdog_cycles = 5 + n_glitches * 35 + glitch_settle
		+ (n_presses + 1) * (285 + tail_wait + press_settle + 63 + 2)
		+ n_holds * (int'(long_cycles) + 100 + 511 + hold_settle + 2)
		+ second_cycles + 500;

	logic       clk;
	logic       reset;
	logic       fire_button;
	msg_block_t block;
	stats_t     stats;

	logic [15:0] lfsr;	// Stimulus source
	string       test_name;
	int          error_count;
	int          cyc;	// Cycles since reset release
	int          header_count;
	int          tail_count;
	int          tail_gap;	// Expected distance to next tail block
	int          last_block_cyc;
	int          fin;
	int          win;
	logic        prev_valid;
	logic [47:0] last_total;
	nonce_t      exp_nonce;
	int          win_cnt [int];	// Expected finishes per rate window

	always #4 clk = ~clk;	// 8 ns period

	sha_miner_top i_sha_miner_top (
		.clk        (clk),
		.reset      (reset),
		.fire_button(fire_button),
		.block      (block),
		.stats      (stats)
	);

	////////////////////////////////////////
	// Failure reporting and checks
	////////////////////////////////////////

	task automatic stop_run();
		error_count++;
		$display("CHECKS FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_failure(input string what);
		$display("Error in %s test: %s", test_name, what);
		stop_run();
	endtask

	task automatic check_eq(input string what, input logic [511:0] expected,
			input logic [511:0] actual);
		assert (actual === expected) else begin
			$display("FAIL %s: %s expected %0h actual %0h", test_name, what, expected, actual);
			stop_run();
		end
	endtask

	////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////

	// Galois form, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic draw(input int nbits, output int value);
		value = 0;
		for (int b = 0; b < nbits; b++) begin
			lfsr  = lfsr_next(lfsr);	// One step per bit
			value = {value[30:0], lfsr[0]};
		end
	endtask

	task automatic drive_button(input logic level, input int cycles);
		fire_button <= level;
		repeat (cycles) @(posedge clk);
	endtask

	task automatic wait_for_tails(input int target, input int limit);
		int waited;
		waited = 0;
		while (tail_count < target) begin
			@(posedge clk);
			waited++;
			assert (waited <= limit)
				else report_failure("no tail block arrived after the press");
		end
	endtask

	// Counts and total sampled mid-cycle at idle
	task automatic check_counts(input int heads, input int tails);
		@(negedge clk);
		check_eq("header blocks", 512'(heads), 512'(header_count));
		check_eq("tail blocks", 512'(tails), 512'(tail_count));
		check_eq("total_ops", 512'(tail_count), 512'(stats.total_ops));
		@(posedge clk);
	endtask

	////////////////////////////////////////
	// Test phases
	////////////////////////////////////////

	task automatic run_glitches();
		int len;
		int gap;
		int heads;
		int tails;
		test_name = "glitch";
		heads     = header_count;
		tails     = tail_count;
		for (int g = 0; g < n_glitches; g++) begin
			draw(4, len);
			draw(4, gap);
			drive_button(1'b1, len + 1);	// At most 16, well under press_cycles
			drive_button(1'b0, gap + 4);
		end
		drive_button(1'b0, glitch_settle);
		check_counts(heads, tails);	// Nothing issued
	endtask

	task automatic run_press();
		int len;
		int gap;
		int heads;
		int tails;
		test_name = "press";
		heads     = header_count;
		tails     = tail_count;
		draw(8, len);
		draw(6, gap);
		drive_button(1'b1, len + 30);	// Past press_cycles, short of long_cycles
		fire_button <= 1'b0;
		wait_for_tails(tails + 1, tail_wait);
		drive_button(1'b0, press_settle + gap);	// Debounce back to idle
		check_counts(heads + 1, tails + 1);
	endtask

	task automatic run_hold();
		int len;
		int hold_len;
		int span;	// Hold rise to its last high cycle
		int repeats;
		int heads;
		int tails;
		test_name = "hold";
		heads     = header_count;
		tails     = tail_count;
		draw(9, len);
		hold_len = int'(long_cycles) + 100 + len;
		// Hold rises long_cycles + 2 after the synchronised rise,
		// last high cycle is release_cycles + 1 after the synchronised fall
		span    = hold_len + int'(release_cycles) + 1 - (int'(long_cycles) + 2);
		repeats = (span - int'(job_last_step)) / 65 + 1;	// Jobs re-entered while held
		drive_button(1'b1, hold_len);
		drive_button(1'b0, hold_settle);
		// Press job is done long before hold rises, hold starts a second job from idle
		check_counts(heads + 2, tails + 2 + repeats);
	endtask

	////////////////////////////////////////
	// Model of block stream and stats
	////////////////////////////////////////

	always @(negedge clk) begin
		if (!reset) begin
			cyc++;
			// Rate latch visible on first cycle of each window
			if (cyc > 0 && cyc % second_cycles == 0) begin
				win = cyc / second_cycles - 1;
				check_eq("ops_per_sec", 512'(win_cnt.exists(win) ? win_cnt[win] : 0),
					512'(stats.ops_per_sec));
			end
			assert (stats.total_ops >= last_total)
				else report_failure("total_ops went down");
			last_total = stats.total_ops;
			if (block.valid) begin
				assert (!prev_valid) else report_failure("block valid held for two cycles");
				if (block.index == 1'b0) begin
					check_eq("header data", header_block, block.data);
					header_count++;
					tail_gap = 64;	// Tail follows header after one block of rounds
				end else begin
					check_eq("tail spacing", 512'(tail_gap), 512'(cyc - last_block_cyc));
					check_eq("tail nonce", 512'(exp_nonce), 512'(block.data[415:384]));
					check_eq("tail data", {tail_prefix, exp_nonce, tail_padding}, block.data);
					exp_nonce++;
					tail_count++;
					tail_gap = 65;	// Repeat jobs, tail only
					fin      = cyc + 62;	// load1 was last cycle, finish 63 after it
					win      = (fin + 1) / second_cycles;	// Finish on a tick counts forward
					if (win_cnt.exists(win))
						win_cnt[win]++;
					else
						win_cnt[win] = 1;
				end
				last_block_cyc = cyc;
			end
			prev_valid = block.valid;
		end
	end

	////////////////////////////////////////
	// Main sequence and watchdog
	////////////////////////////////////////

	initial begin
		clk            = 1'b0;
		reset          = 1'b1;
		fire_button    = 1'b0;
		lfsr           = 16'(seed);
		test_name      = "reset";
		error_count    = 0;
		cyc            = -1;
		header_count   = 0;
		tail_count     = 0;
		tail_gap       = 64;
		last_block_cyc = -1000;
		prev_valid     = 1'b0;
		last_total     = '0;
		exp_nonce      = '0;	// First job carries nonce 0
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		run_glitches();
		for (int p = 0; p < n_presses; p++)
			run_press();
		for (int h = 0; h < n_holds; h++)
			run_hold();
		run_press();	// Nonce carries on after holds
		test_name = "rate window";
		drive_button(1'b0, second_cycles + 2);	// One more window latch
		if (error_count == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		report_failure("watchdog expired before the tests finished");
	end

endmodule

`default_nettype wire

// File: sources.f
source/sha_miner_pkg.sv
source/button_debounce.sv
source/hash_sequencer.sv
source/message_builder.sv
source/rate_counter.sv
source/sha_miner_top.sv
dv/sha_miner_chk.sv
dv/tb_sha_miner.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the sha_miner testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -f sources.f --top-module tb_sha_miner \
	-Mdir "$build_dir" -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

# Keep running past assertion errors so the testbench reports them
"./$build_dir/sim_tb" +verilator+error+limit+100 > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "ALL CHECKS PASSED" "$log_file"; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed, see $log_file"
	exit 1
fi
